// ==== source/fetch_pkg.sv ====
/*
 * Fetch frontend package
 * Address and block widths, BTB and queue sizes, and the shared structs
 */

`default_nettype none

package fetch_pkg;

  // ======================================================================
  // Widths and sizes
  // ======================================================================
  localparam int unsigned VADDR_W     = 32;
  localparam int unsigned INST_W      = 32;
  localparam int unsigned BLOCK_INSTS = 4;
  localparam int unsigned BLOCK_W     = INST_W * BLOCK_INSTS;  // 128
  localparam int unsigned BLOCK_BYTES = 16;
  localparam int unsigned BLOCK_OFS_W = 4;

  localparam logic [VADDR_W-1:0] RESET_PC = 32'h0000_1000;

  localparam int unsigned BTB_ENTRIES = 16;
  localparam int unsigned BTB_IDX_W   = 4;
  localparam int unsigned BTB_TAG_W   = VADDR_W - BTB_IDX_W - BLOCK_OFS_W;

  localparam int unsigned FQ_DEPTH = 4;
  localparam int unsigned FQ_PTR_W = 2;  // Must cover FQ_DEPTH

  // ======================================================================
  // Shared types
  // ======================================================================
  typedef logic [VADDR_W-1:0] vaddr_t;
  typedef logic [BLOCK_W-1:0] block_t;

  typedef struct packed {
    logic   valid;
    vaddr_t target;
  } redirect_t;

  typedef struct packed {
    logic   valid;
    logic   taken;
    vaddr_t pc;
    vaddr_t target;
  } btb_update_t;

  typedef struct packed {
    logic   hit;
    vaddr_t target;
  } btb_pred_t;

  typedef struct packed {
    vaddr_t pc;
    block_t data;
    logic   pred_taken;
    vaddr_t pred_target;
  } fetch_block_t;

endpackage

`default_nettype wire

// ==== source/fetch_pc_gen.sv ====
/*
 * Fetch address generation (f0)
 * Holds the current fetch block address and picks the next one from
 * redirect, BTB prediction or the sequential block
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_pc_gen (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset_n,
  input  wire fetch_pkg::redirect_t  i_redirect,
  input  wire logic                  i_launch,
  input  wire fetch_pkg::btb_pred_t  i_pred,
  output fetch_pkg::vaddr_t          o_pc
);

  fetch_pkg::vaddr_t r_pc;
  fetch_pkg::vaddr_t w_pc_seq;
  fetch_pkg::vaddr_t w_pc_next;

  // Clear the offset bits below the block boundary
  function automatic fetch_pkg::vaddr_t align_block(input fetch_pkg::vaddr_t addr);
    fetch_pkg::vaddr_t mask;
    mask = fetch_pkg::vaddr_t'(fetch_pkg::BLOCK_BYTES - 1);
    return addr & ~mask;
  endfunction

  // ======================================================================
  // Next block address
  // ======================================================================
  assign w_pc_seq = r_pc + fetch_pkg::vaddr_t'(fetch_pkg::BLOCK_BYTES);

  always_comb begin
    if (i_redirect.valid) begin
      // Back end wins over everything
      w_pc_next = align_block(i_redirect.target);
    end else if (i_launch) begin
      if (i_pred.hit) begin
        w_pc_next = align_block(i_pred.target);  // Taken prediction
      end else begin
        w_pc_next = w_pc_seq;
      end
    end else begin
      w_pc_next = r_pc;  // No access started, hold
    end
  end

  // ======================================================================
  // Fetch PC register
  // ======================================================================
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_pc <= fetch_pkg::RESET_PC;
    end else begin
      r_pc <= w_pc_next;
    end
  end

  assign o_pc = r_pc;

endmodule

`default_nettype wire

// ==== source/fetch_btb.sv ====
/*
 * Branch target buffer
 * Direct mapped, combinational lookup, trained by branch resolution
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_btb (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,
  input  wire fetch_pkg::vaddr_t       i_lookup_pc,
  output fetch_pkg::btb_pred_t         o_pred,
  input  wire fetch_pkg::btb_update_t  i_update
);

  logic [fetch_pkg::BTB_ENTRIES-1:0] r_valid;
  logic [fetch_pkg::BTB_TAG_W-1:0]   r_tag    [fetch_pkg::BTB_ENTRIES];
  fetch_pkg::vaddr_t                 r_target [fetch_pkg::BTB_ENTRIES];

  logic [fetch_pkg::BTB_IDX_W-1:0] w_lk_idx;
  logic [fetch_pkg::BTB_TAG_W-1:0] w_lk_tag;
  logic [fetch_pkg::BTB_IDX_W-1:0] w_up_idx;
  logic [fetch_pkg::BTB_TAG_W-1:0] w_up_tag;
  logic                            w_up_hit;

  // ======================================================================
  // Lookup
  // ======================================================================
  assign w_lk_idx = i_lookup_pc[fetch_pkg::BLOCK_OFS_W +: fetch_pkg::BTB_IDX_W];
  assign w_lk_tag = i_lookup_pc[fetch_pkg::VADDR_W-1 -: fetch_pkg::BTB_TAG_W];

  assign o_pred.hit    = r_valid[w_lk_idx] && (r_tag[w_lk_idx] == w_lk_tag);
  assign o_pred.target = r_target[w_lk_idx];

  // ======================================================================
  // Update from branch resolution
  // ======================================================================
  assign w_up_idx = i_update.pc[fetch_pkg::BLOCK_OFS_W +: fetch_pkg::BTB_IDX_W];
  assign w_up_tag = i_update.pc[fetch_pkg::VADDR_W-1 -: fetch_pkg::BTB_TAG_W];
  assign w_up_hit = r_valid[w_up_idx] && (r_tag[w_up_idx] == w_up_tag);

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_valid <= '0;
    end else if (i_update.valid) begin
      if (i_update.taken) begin
        r_valid[w_up_idx] <= 1'b1;
      end else if (w_up_hit) begin
        r_valid[w_up_idx] <= 1'b0;  // Only drop our own entry
      end
    end
  end

  // Tag and target only change on a taken update
  always_ff @(posedge i_clk) begin
    if (i_update.valid && i_update.taken) begin
      r_tag[w_up_idx]    <= w_up_tag;
      r_target[w_up_idx] <= i_update.target;
    end
  end

  // An entry cleared by a not-taken update stops hitting at once
  a_hit_valid: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (i_update.valid && !i_update.taken && w_up_hit) |=>
      !(o_pred.hit && (w_lk_idx == $past(w_up_idx)))
  ) else $error("fetch_btb: hit reported on an invalid entry");

endmodule

`default_nettype wire

// ==== source/fetch_mem_port.sv ====
/*
 * Instruction memory port (f1)
 * Four-phase req/ack master, one access at a time; builds the fetched
 * block and drops data made stale by a flush
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_mem_port (
  input  wire logic                  i_clk,
  input  wire logic                  i_reset_n,
  input  wire fetch_pkg::vaddr_t     i_pc,
  input  wire fetch_pkg::btb_pred_t  i_pred,
  input  wire logic                  i_flush,
  input  wire logic                  i_q_full,
  output logic                       o_launch,
  output logic                       o_mem_req,
  output fetch_pkg::vaddr_t          o_mem_addr,
  input  wire logic                  i_mem_ack,
  input  wire fetch_pkg::block_t     i_mem_data,
  output logic                       o_push,
  output fetch_pkg::fetch_block_t    o_push_block
);

  typedef enum logic [1:0] {
    s_idle,
    s_req,      // req high, waiting for ack
    s_release,  // req low, waiting for ack to fall
    s_push
  } state_t;

  state_t               r_state;
  state_t               w_state_next;
  logic                 r_stale;
  fetch_pkg::vaddr_t    r_addr;
  fetch_pkg::btb_pred_t r_pred;
  fetch_pkg::block_t    r_data;

  // ======================================================================
  // Handshake FSM
  // ======================================================================
  assign o_launch = (r_state == s_idle) && !i_q_full && !i_flush;

  always_comb begin
    w_state_next = r_state;
    case (r_state)
      s_idle:    if (o_launch) w_state_next = s_req;
      s_req:     if (i_mem_ack) w_state_next = s_release;
      s_release: if (!i_mem_ack) w_state_next = s_push;
      s_push:    w_state_next = s_idle;
      default:   w_state_next = s_idle;
    endcase
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_state <= s_idle;
      r_stale <= 1'b0;
    end else begin
      r_state <= w_state_next;
      if (o_launch) begin
        r_stale <= 1'b0;
      end else if (i_flush && (r_state != s_idle)) begin
        r_stale <= 1'b1;  // Redirect hit an access in flight
      end
    end
  end

  // Address and prediction belong to the block launched
  always_ff @(posedge i_clk) begin
    if (o_launch) begin
      r_addr <= i_pc;
      r_pred <= i_pred;
    end
    if ((r_state == s_req) && i_mem_ack) begin
      r_data <= i_mem_data;
    end
  end

  assign o_mem_req  = (r_state == s_req);
  assign o_mem_addr = r_addr;

  // ======================================================================
  // Push towards the fetch queue
  // ======================================================================
  assign o_push = (r_state == s_push) && !r_stale && !i_flush;

  assign o_push_block.pc          = r_addr;
  assign o_push_block.data        = r_data;
  assign o_push_block.pred_taken  = r_pred.hit;
  assign o_push_block.pred_target = r_pred.target;

  // ======================================================================
  // Protocol checks
  // ======================================================================
  a_req_hold: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (o_mem_req && !i_mem_ack) |=> o_mem_req
  ) else $error("fetch_mem_port: req dropped before ack");

  a_addr_stable: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_mem_req |=> (!o_mem_req || $stable(o_mem_addr))
  ) else $error("fetch_mem_port: address changed during request");

endmodule

`default_nettype wire

// ==== source/fetch_queue.sv ====
/*
 * Fetch queue (f2)
 * Circular FIFO of fetched blocks towards decode, cleared on redirect
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
  parameter type T_ENTRY = logic
) (
  input  wire logic    i_clk,
  input  wire logic    i_reset_n,
  input  wire logic    i_clear,
  input  wire logic    i_push,
  input  wire T_ENTRY  i_push_data,
  output logic         o_full,
  output logic         o_valid,
  output T_ENTRY       o_data,
  input  wire logic    i_ready
);

  T_ENTRY                      r_mem [fetch_pkg::FQ_DEPTH];
  logic [fetch_pkg::FQ_PTR_W-1:0] r_wr_ptr;
  logic [fetch_pkg::FQ_PTR_W-1:0] r_rd_ptr;
  logic [fetch_pkg::FQ_PTR_W:0]   r_count;
  logic                        w_pop;

  assign w_pop   = o_valid && i_ready;
  assign o_valid = (r_count != '0);
  assign o_full  = (r_count == (fetch_pkg::FQ_PTR_W + 1)'(fetch_pkg::FQ_DEPTH));
  assign o_data  = r_mem[r_rd_ptr];

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else if (i_clear) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
      r_count  <= '0;
    end else begin
      if (i_push) r_wr_ptr <= r_wr_ptr + 1'b1;
      if (w_pop)  r_rd_ptr <= r_rd_ptr + 1'b1;
      case ({i_push, w_pop})
        2'b10:   r_count <= r_count + 1'b1;
        2'b01:   r_count <= r_count - 1'b1;
        default: r_count <= r_count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      r_mem[r_wr_ptr] <= i_push_data;
    end
  end

  // Producer must hold off while full
  a_no_overflow: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_push |-> !o_full
  ) else $error("fetch_queue: push while full");

endmodule

`default_nettype wire

// ==== source/fetch_frontend.sv ====
/*
 * Instruction fetch frontend top
 * PC generation, BTB, memory port and fetch queue wired together
 */

`timescale 1ns/1ps
`default_nettype none

module fetch_frontend (
  input  wire logic                    i_clk,
  input  wire logic                    i_reset_n,
  input  wire fetch_pkg::redirect_t    i_redirect,
  input  wire fetch_pkg::btb_update_t  i_btb_update,
  output logic                         o_mem_req,
  output fetch_pkg::vaddr_t            o_mem_addr,
  input  wire logic                    i_mem_ack,
  input  wire fetch_pkg::block_t       i_mem_data,
  output logic                         o_fetch_valid,
  output fetch_pkg::fetch_block_t      o_fetch,
  input  wire logic                    i_fetch_ready
);

  fetch_pkg::vaddr_t       w_pc;
  fetch_pkg::btb_pred_t    w_pred;
  logic                    w_launch;
  logic                    w_push;
  fetch_pkg::fetch_block_t w_push_block;
  logic                    w_q_full;

  // ======================================================================
  // f0
  // ======================================================================
  fetch_pc_gen u_pc_gen (
    .i_clk      (i_clk),
    .i_reset_n  (i_reset_n),
    .i_redirect (i_redirect),
    .i_launch   (w_launch),
    .i_pred     (w_pred),
    .o_pc       (w_pc)
  );

  fetch_btb u_btb (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_lookup_pc (w_pc),
    .o_pred      (w_pred),
    .i_update    (i_btb_update)
  );

  // ======================================================================
  // f1 and f2
  // ======================================================================
  fetch_mem_port u_mem_port (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .i_pc         (w_pc),
    .i_pred       (w_pred),
    .i_flush      (i_redirect.valid),
    .i_q_full     (w_q_full),
    .o_launch     (w_launch),
    .o_mem_req    (o_mem_req),
    .o_mem_addr   (o_mem_addr),
    .i_mem_ack    (i_mem_ack),
    .i_mem_data   (i_mem_data),
    .o_push       (w_push),
    .o_push_block (w_push_block)
  );

  fetch_queue #(.T_ENTRY(fetch_pkg::fetch_block_t)) u_queue (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_clear     (i_redirect.valid),
    .i_push      (w_push),
    .i_push_data (w_push_block),
    .o_full      (w_q_full),
    .o_valid     (o_fetch_valid),
    .o_data      (o_fetch),
    .i_ready     (i_fetch_ready)
  );

endmodule

`default_nettype wire

// ==== sim/tb_clock_gen.sv ====
/*
 * Testbench clock and reset
 * 20 ns clock, active low reset held for the first 4 cycles
 */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic o_clk,
  output logic o_reset_n
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;
  end

  initial begin
    o_reset_n = 1'b0;
    repeat (4) @(posedge o_clk);
    o_reset_n <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== sim/tb_imem_model.sv ====
/*
 * Instruction memory model
 * Four-phase responder with a random ack delay, data derived from the address
 */

`timescale 1ns/1ps
`default_nettype none

module tb_imem_model (
  input  wire logic               i_clk,
  input  wire logic               i_reset_n,
  input  wire logic               i_req,
  input  wire fetch_pkg::vaddr_t  i_addr,
  output logic                    o_ack,
  output fetch_pkg::block_t       o_data
);

  integer     seed = 32'h9787;
  integer     roll;
  logic [2:0] r_delay;
  logic       r_busy;  // Request seen, ack not raised yet

  // Word i holds its own byte address XOR a fixed pattern
  function automatic fetch_pkg::block_t read_block(input fetch_pkg::vaddr_t addr);
    fetch_pkg::block_t blk;
    fetch_pkg::vaddr_t base;
    base = addr & ~fetch_pkg::vaddr_t'(fetch_pkg::BLOCK_BYTES - 1);
    for (int i = 0; i < fetch_pkg::BLOCK_INSTS; i++) begin
      blk[i*fetch_pkg::INST_W +: fetch_pkg::INST_W] = (base + 32'(4 * i)) ^ 32'hA5A5_0000;
    end
    return blk;
  endfunction

  always @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      o_ack   <= 1'b0;
      o_data  <= '0;
      r_busy  <= 1'b0;
      r_delay <= '0;
    end else if (o_ack) begin
      if (!i_req) o_ack <= 1'b0;  // Master took the data
    end else if (r_busy) begin
      if (r_delay == 3'd0) begin
        o_ack  <= 1'b1;
        o_data <= read_block(i_addr);
        r_busy <= 1'b0;
      end else begin
        r_delay <= r_delay - 3'd1;
      end
    end else if (i_req) begin
      roll = $random(seed);
      r_delay <= 3'(unsigned'(roll) % 6);  // 0 to 5 extra cycles
      r_busy  <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== sim/tb_fetch_frontend.sv ====
/*
 * Fetch frontend testbench
 * Drives redirects, BTB updates and decode back-pressure, and checks the
 * block stream against a reference PC and BTB model
 */

`timescale 1ns/1ps
`default_nettype none

module tb_fetch_frontend;

  // ======================================================================
  // Test lengths and watchdog
  // ======================================================================
  localparam int N_SEQ_BLOCKS  = 40;
  localparam int N_REDIRECTS   = 24;
  localparam int N_BP_BLOCKS   = 98;
  localparam int N_ALL_BLOCKS  = N_SEQ_BLOCKS + 16 + 4 * N_REDIRECTS + N_BP_BLOCKS;
  localparam int MAX_BLOCK_CYC = 10;  // Launch, ack delay, release, push
  localparam int STALL_FACTOR  = 4;   // Back-pressure and flushed accesses
  localparam int WATCHDOG_NS   = N_ALL_BLOCKS * MAX_BLOCK_CYC * 20 * STALL_FACTOR;

  localparam fetch_pkg::vaddr_t BR_PC     = 32'h0000_8000;
  localparam fetch_pkg::vaddr_t BR_TARGET = 32'h0000_6000;

  logic w_clk;
  logic w_reset_n;
  logic w_mem_req;
  logic w_mem_ack;
  logic w_fetch_valid;
  fetch_pkg::vaddr_t       w_mem_addr;
  fetch_pkg::block_t       w_mem_data;
  fetch_pkg::fetch_block_t w_fetch;
  fetch_pkg::redirect_t    r_redirect;
  fetch_pkg::btb_update_t  r_btb_update;
  logic r_fetch_ready = 1'b0;
  logic r_bp_mode     = 1'b0;
  int   r_stall_left  = 0;

  integer      seed = 32'h9787;
  logic [31:0] stim_roll;
  logic [31:0] ready_roll;
  int   n_proto_err = 0;
  int   n_data_err  = 0;
  int   n_xfer      = 0;
  int   n_pending   = 0;  // Launched, not yet taken by decode
  logic prev_req;
  logic req_rose;
  fetch_pkg::vaddr_t exp_pc;
  logic              m_btb_valid = 1'b0;  // Reference BTB, one trained branch
  fetch_pkg::vaddr_t m_btb_pc;
  fetch_pkg::vaddr_t m_btb_target;

  tb_clock_gen u_clk_gen (.o_clk(w_clk), .o_reset_n(w_reset_n));

  tb_imem_model u_imem (
    .i_clk(w_clk), .i_reset_n(w_reset_n), .i_req(w_mem_req), .i_addr(w_mem_addr),
    .o_ack(w_mem_ack), .o_data(w_mem_data)
  );

  fetch_frontend uut (
    .i_clk(w_clk), .i_reset_n(w_reset_n), .i_redirect(r_redirect),
    .i_btb_update(r_btb_update), .o_mem_req(w_mem_req), .o_mem_addr(w_mem_addr),
    .i_mem_ack(w_mem_ack), .i_mem_data(w_mem_data), .o_fetch_valid(w_fetch_valid),
    .o_fetch(w_fetch), .i_fetch_ready(r_fetch_ready)
  );

  function automatic fetch_pkg::vaddr_t block_base(input fetch_pkg::vaddr_t addr);
    return addr & ~32'h0000_000F;
  endfunction

  function automatic fetch_pkg::block_t expected_data(input fetch_pkg::vaddr_t pc);
    fetch_pkg::block_t blk;
    for (int i = 0; i < 4; i++) begin
      blk[i*32 +: 32] = (pc + 32'(4 * i)) ^ 32'hA5A5_0000;
    end
    return blk;
  endfunction

  function automatic logic btb_model_hit(input fetch_pkg::vaddr_t pc);
    return m_btb_valid && (pc[31:4] == m_btb_pc[31:4]);
  endfunction

  task automatic report_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
    n_data_err++;
    $display("Mismatch %s expected %0h actual %0h (block %0d)", name, expected, actual, n_xfer);
  endtask

  // ======================================================================
  // Protocol assertions
  // ======================================================================
  a_req_reset: assert property (@(posedge w_clk) !w_reset_n |-> !w_mem_req)
    else begin
      n_proto_err++;
      $display("Memory request high during reset");
    end
  a_req_hold: assert property (@(posedge w_clk) disable iff (!w_reset_n)
    (w_mem_req && !w_mem_ack) |=> w_mem_req)
    else begin
      n_proto_err++;
      $display("Memory request dropped before ack");
    end
  a_req_wait: assert property (@(posedge w_clk) disable iff (!w_reset_n)
    (!w_mem_req && w_mem_ack) |=> !w_mem_req)
    else begin
      n_proto_err++;
      $display("New memory request raised before ack fell");
    end
  a_addr_stable: assert property (@(posedge w_clk) disable iff (!w_reset_n)
    w_mem_req |=> (!w_mem_req || $stable(w_mem_addr)))
    else begin
      n_proto_err++;
      $display("Memory address changed during a request");
    end
  a_fetch_hold: assert property (@(posedge w_clk) disable iff (!w_reset_n)
    (w_fetch_valid && !r_fetch_ready && !r_redirect.valid) |=>
    (w_fetch_valid && $stable(w_fetch)))
    else begin
      n_proto_err++;
      $display("Fetch output changed while decode stalled");
    end

  // ======================================================================
  // Reference model, sampled at the falling edge
  // ======================================================================
  task automatic check_transfer();
    logic exp_taken;
    exp_taken = btb_model_hit(exp_pc);
    assert (w_fetch.pc == exp_pc)
      else report_mismatch("o_fetch.pc", 128'(exp_pc), 128'(w_fetch.pc));
    assert (w_fetch.data == expected_data(exp_pc))
      else report_mismatch("o_fetch.data", expected_data(exp_pc), w_fetch.data);
    assert (w_fetch.pred_taken == exp_taken)
      else report_mismatch("o_fetch.pred_taken", 128'(exp_taken), 128'(w_fetch.pred_taken));
    if (exp_taken) begin
      assert (w_fetch.pred_target == m_btb_target)
        else report_mismatch("o_fetch.pred_target", 128'(m_btb_target),
                             128'(w_fetch.pred_target));
      exp_pc = block_base(m_btb_target);
    end else begin
      exp_pc = exp_pc + fetch_pkg::BLOCK_BYTES;
    end
    n_xfer++;
  endtask

  always @(negedge w_clk) begin
    if (!w_reset_n) begin
      exp_pc    = fetch_pkg::RESET_PC;
      n_pending = 0;
      prev_req  = 1'b0;
    end else begin
      req_rose = w_mem_req && !prev_req;
      prev_req = w_mem_req;
      if (r_redirect.valid) begin
        n_pending = 0;  // Queue emptied, access in flight goes stale
        exp_pc    = block_base(r_redirect.target);
      end else begin
        if (req_rose) begin
          assert (n_pending < fetch_pkg::FQ_DEPTH) else begin
            n_proto_err++;
            $display("Request launched while %0d blocks were already waiting", n_pending);
          end
          n_pending++;
        end
        if (w_fetch_valid && r_fetch_ready) begin
          check_transfer();
          n_pending--;
        end
      end
    end
  end

  // ======================================================================
  // Stimulus
  // ======================================================================
  always @(posedge w_clk) begin
    if (!r_bp_mode) begin
      r_fetch_ready <= 1'b1;
    end else if (r_stall_left != 0) begin
      r_fetch_ready <= 1'b0;
      r_stall_left  <= r_stall_left - 1;
    end else begin
      ready_roll = $random(seed);
      if (ready_roll[4:0] == 5'd0) begin
        r_stall_left  <= 12 + int'(ready_roll[9:5]);  // Long stall, queue fills up
        r_fetch_ready <= 1'b0;
      end else begin
        r_fetch_ready <= ready_roll[6];
      end
    end
  end

  task automatic wait_blocks(input int count);
    int target;
    target = n_xfer + count;
    while (n_xfer < target) @(posedge w_clk);
  endtask

  task automatic send_redirect(input fetch_pkg::vaddr_t target);
    @(posedge w_clk);
    r_redirect.valid  <= 1'b1;
    r_redirect.target <= target;
    @(posedge w_clk);
    r_redirect <= '0;
  endtask

  task automatic send_update(input logic taken, input fetch_pkg::vaddr_t pc,
                             input fetch_pkg::vaddr_t target);
    @(posedge w_clk);
    r_btb_update.valid  <= 1'b1;
    r_btb_update.taken  <= taken;
    r_btb_update.pc     <= pc;
    r_btb_update.target <= target;
    if (taken) begin
      m_btb_valid  = 1'b1;
      m_btb_pc     = pc;
      m_btb_target = target;
    end else if (btb_model_hit(pc)) begin
      m_btb_valid = 1'b0;
    end
    @(posedge w_clk);
    r_btb_update <= '0;
  endtask

  initial begin
    r_redirect   = '0;
    r_btb_update = '0;
    wait (w_reset_n === 1'b1);
    @(posedge w_clk);
    wait_blocks(N_SEQ_BLOCKS);

    // Train, fetch through the predicted branch, then untrain
    send_update(1'b1, BR_PC, BR_TARGET);
    repeat (2) @(posedge w_clk);
    send_redirect(BR_PC);
    wait_blocks(4);
    send_update(1'b0, BR_PC, '0);
    repeat (2) @(posedge w_clk);
    send_redirect(BR_PC + 32'h4);  // Unaligned target
    wait_blocks(4);

    r_bp_mode <= 1'b1;
    for (int i = 0; i < N_REDIRECTS; i++) begin
      do @(posedge w_clk); while (!w_mem_req);
      stim_roll = $random(seed);
      repeat (stim_roll[1:0]) @(posedge w_clk);
      send_redirect(32'h0000_2000 + (stim_roll & 32'h0000_0FFF));
      wait_blocks(1 + int'(stim_roll[13:12]));
    end
    wait_blocks(N_BP_BLOCKS);
    repeat (10) @(posedge w_clk);

    $display("Closing report: %0d blocks checked, %0d protocol errors, %0d data errors",
             n_xfer, n_proto_err, n_data_err);
    if ((n_proto_err == 0) && (n_data_err == 0)) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns with %0d blocks checked", WATCHDOG_NS, n_xfer);
    $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
source/fetch_pkg.sv
source/fetch_pc_gen.sv
source/fetch_btb.sv
source/fetch_mem_port.sv
source/fetch_queue.sv
source/fetch_frontend.sv
sim/tb_clock_gen.sv
sim/tb_imem_model.sv
sim/tb_fetch_frontend.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the fetch frontend testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_fetch_frontend \
  --Mdir obj_dir \
  -f sim.f

status=0
./obj_dir/Vtb_fetch_frontend > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "Something failed" "$LOG"; then
  echo "FAIL: testbench reported a failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "FAIL: simulator exited with status $status"
  exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
  echo "FAIL: run ended without a result"
  exit 1
fi
echo "PASS"
